// ==== Makefile ====
TOP = tb_dhcp_client

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
verilog/net_pkg.sv
verilog/dhcp_pkg.sv
verilog/dhcp_rx.sv
verilog/dhcp_tx.sv
verilog/dhcp_core.sv
verilog/dhcp_client.sv
testbench/tb_dhcp_client.sv

// ==== testbench/tb_dhcp_client.sv ====
module tb_dhcp_client;

  timeunit 1ns;
  timeprecision 100ps;

  import dhcp_pkg::*;
  import net_pkg::*;

  typedef enum {pol_offer, pol_bad_xid, pol_bad_port, pol_silent} offer_pol_t;

  typedef struct {
    offer_pol_t pol;       // how the first n_bad discovers are answered
    int         n_bad;
    bit         nak_first; // nak the first request of the row
    bit         exp_ok;
    int         exp_disc;
  } row_t;

  localparam int NUM_ROWS   = 6;
  localparam int MAX_CYCLES = NUM_ROWS *
    (int'(MAX_TRIES) * (int'(TIMEOUT_CYCLES) + int'(REQ_LEN) + 50) + 600);

  logic        clk;
  logic        fsm_rst;
  logic        rx_v;
  logic [7:0]  rx_d;
  logic        rx_sof;
  logic        rx_eof;
  logic [15:0] rx_src_port;
  mac_t        mac_addr;
  logic        ipv4_req;
  ipv4_t       pref_ipv4;
  logic        tx_v;
  logic [7:0]  tx_d;
  logic        tx_sof;
  logic        tx_eof;
  ipv4_t       ipv4_addr;
  logic        ipv4_val;
  logic        dhcp_ok;
  logic        dhcp_timeout;

  row_t        rows [NUM_ROWS];
  logic [31:0] offer_ip [NUM_ROWS];
  logic [31:0] srv_ip [NUM_ROWS];
  logic [7:0]  pkt [512]; // last captured tx packet
  int          pkt_len;
  int          val_cnt = 0;
  int          cycle_cnt = 0;
  integer      seed = 32'h397a_0c11;

  dhcp_client u_dhcp_client (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .rx_v         (rx_v),
    .rx_d         (rx_d),
    .rx_sof       (rx_sof),
    .rx_eof       (rx_eof),
    .rx_src_port  (rx_src_port),
    .mac_addr     (mac_addr),
    .ipv4_req     (ipv4_req),
    .pref_ipv4    (pref_ipv4),
    .tx_v         (tx_v),
    .tx_d         (tx_d),
    .tx_sof       (tx_sof),
    .tx_eof       (tx_eof),
    .ipv4_addr    (ipv4_addr),
    .ipv4_val     (ipv4_val),
    .dhcp_ok      (dhcp_ok),
    .dhcp_timeout (dhcp_timeout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (ipv4_val) val_cnt++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES)
      stop_run($sformatf("timeout: no result after %0d clock cycles", MAX_CYCLES));
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    assert (got == exp)
      else stop_run($sformatf("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  function automatic logic [31:0] word_at(input int ofs);
    return {pkt[ofs], pkt[ofs+1], pkt[ofs+2], pkt[ofs+3]};
  endfunction

  // walk the options area, returns the index of the data bytes or -1
  function automatic int find_opt(input logic [7:0] code);
    int i;
    i = int'(HDR_LEN);
    while (i < pkt_len) begin
      if (pkt[i] == code) return i + 2;
      if (pkt[i] == 8'd255) return -1;
      if (pkt[i] == 8'd0) i++;
      else i = i + 2 + int'(pkt[i+1]);
    end
    return -1;
  endfunction

  // got stays 0 when dhcp_timeout rises before any tx byte
  task automatic capture_packet(output bit got);
    bit done;
    got = 1'b0;
    done = 1'b0;
    pkt_len = 0;
    while (!done) begin
      @(negedge clk);
      if (tx_v) begin
        expect_equal(32'(tx_sof), 32'(pkt_len == 0), "tx_sof");
        if (pkt_len < 512) pkt[pkt_len] = tx_d;
        pkt_len++;
        got = 1'b1;
        done = tx_eof;
      end else if (got) begin
        stop_run("tx_v dropped before tx_eof was seen");
      end else if (dhcp_timeout) begin
        done = 1'b1;
      end
    end
  endtask

  task automatic send_reply(input logic [7:0] msg, input logic [31:0] rxid,
                            input logic [31:0] yi, input logic [31:0] srv,
                            input logic [15:0] port);
    logic [7:0] rbuf [256];
    int i;
    for (i = 0; i < 256; i++) rbuf[i] = 8'h00;
    rbuf[0] = 8'd2; // boot reply
    rbuf[1] = 8'd1;
    rbuf[2] = 8'd6;
    for (i = 0; i < 4; i++) begin
      rbuf[4+i]   = rxid[31-8*i -: 8];
      rbuf[16+i]  = yi[31-8*i -: 8];
      rbuf[236+i] = MAGIC_COOKIE[3-i];
      rbuf[245+i] = srv[31-8*i -: 8];
      rbuf[251+i] = 8'h10 + 8'(i); // lease time, parser skips it
    end
    for (i = 0; i < 6; i++) rbuf[28+i] = mac_addr[5-i];
    rbuf[240] = 8'd53;
    rbuf[241] = 8'd1;
    rbuf[242] = msg;
    rbuf[243] = 8'd54;
    rbuf[244] = 8'd4;
    rbuf[249] = 8'd51;
    rbuf[250] = 8'd4;
    rbuf[255] = 8'd255;
    for (i = 0; i < 256; i++) begin
      @(negedge clk);
      rx_v        = 1'b1;
      rx_d        = rbuf[i];
      rx_sof      = (i == 0);
      rx_eof      = (i == 255);
      rx_src_port = port;
    end
    @(negedge clk);
    rx_v   = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
  endtask

  task automatic check_discover();
    int i;
    expect_equal(pkt_len, DISC_LEN, "discover length");
    expect_equal(pkt[0], 8'd1, "discover op");
    for (i = 0; i < 6; i++) expect_equal(pkt[28+i], mac_addr[5-i], "discover chaddr byte");
    expect_equal(word_at(236), MAGIC_COOKIE, "discover cookie");
    i = find_opt(opt_msg_type);
    assert (i > 0) else stop_run("discover carries no message type option");
    expect_equal(pkt[i], 8'd1, "discover message type");
  endtask

  task automatic check_request(input int r, input logic [31:0] offer_xid);
    int i;
    expect_equal(pkt_len, REQ_LEN, "request length");
    expect_equal(word_at(4), offer_xid, "request xid");
    i = find_opt(opt_msg_type);
    assert (i > 0) else stop_run("request carries no message type option");
    expect_equal(pkt[i], 8'd3, "request message type");
    i = find_opt(opt_req_ip);
    assert (i > 0) else stop_run("request carries no requested address option");
    expect_equal(word_at(i), offer_ip[r], "request req_ip");
    i = find_opt(opt_server_id);
    assert (i > 0) else stop_run("request carries no server id option");
    expect_equal(word_at(i), srv_ip[r], "request server_id");
  endtask

  task automatic check_lease(input int r, input int base_val);
    while (!dhcp_ok) begin
      @(negedge clk);
      if (dhcp_timeout) stop_run("dhcp_timeout rose while waiting for dhcp_ok");
    end
    expect_equal(ipv4_addr, offer_ip[r], "ipv4_addr");
    repeat (20) @(negedge clk); // dhcp_ok must hold, no second pulse
    expect_equal(32'(dhcp_ok), 32'd1, "dhcp_ok after lease");
    expect_equal(val_cnt - base_val, 1, "ipv4_val pulse count");
  endtask

  initial begin
    int r;
    int disc_n;
    int req_n;
    int base_val;
    bit got;
    bit finished;
    bit after_nak;
    logic [31:0] cur_xid;
    logic [31:0] nak_xid;
    fsm_rst     = 1'b1;
    rx_v        = 1'b0;
    rx_d        = 8'h00;
    rx_sof      = 1'b0;
    rx_eof      = 1'b0;
    rx_src_port = 16'd0;
    mac_addr    = 48'h02_1a_2b_3c_4d_5e;
    ipv4_req    = 1'b0;
    pref_ipv4   = {8'd192, 8'd168, 8'd1, 8'd77};
    rows[0] = '{pol_offer, 0, 1'b0, 1'b1, 1};
    rows[1] = '{pol_bad_xid, 1, 1'b0, 1'b1, 2};
    rows[2] = '{pol_bad_port, 1, 1'b0, 1'b1, 2};
    rows[3] = '{pol_offer, 0, 1'b1, 1'b1, 2};
    rows[4] = '{pol_silent, 3, 1'b0, 1'b0, int'(MAX_TRIES)};
    rows[5] = '{pol_offer, 0, 1'b0, 1'b1, 1}; // restart out of failed
    for (r = 0; r < NUM_ROWS; r++) begin
      offer_ip[r] = {8'd10, 8'd20, 8'($random(seed)), 8'($random(seed))};
      srv_ip[r]   = {8'd10, 8'd20, 8'd0, 8'($random(seed))};
    end
    repeat (3) @(negedge clk);
    fsm_rst = 1'b0;

    for (r = 0; r < NUM_ROWS; r++) begin
      disc_n    = 0;
      req_n     = 0;
      after_nak = 1'b0;
      finished  = 1'b0;
      base_val  = val_cnt;
      cur_xid   = 32'd0;
      nak_xid   = 32'd0;
      @(negedge clk);
      ipv4_req = 1'b1;
      @(negedge clk);
      ipv4_req = 1'b0;
      while (!finished) begin
        capture_packet(got);
        if (!got) begin
          assert (!rows[r].exp_ok)
            else stop_run($sformatf("ERR %0t: row %0d timed out, lease expected", $time, r));
          expect_equal(32'(dhcp_ok), 32'd0, "dhcp_ok with dhcp_timeout");
          finished = 1'b1;
        end else if (pkt_len == int'(DISC_LEN) || find_opt(opt_req_ip) < 0) begin
          check_discover();
          disc_n++;
          cur_xid = word_at(4);
          if (after_nak) expect_equal(32'(cur_xid != nak_xid), 32'd1, "new xid after nak");
          after_nak = 1'b0;
          if (disc_n > rows[r].n_bad)
            send_reply(8'd2, cur_xid, offer_ip[r], srv_ip[r], DHCP_SRV_PORT);
          else if (rows[r].pol == pol_bad_xid)
            send_reply(8'd2, cur_xid ^ 32'h0000_0100, offer_ip[r], srv_ip[r], DHCP_SRV_PORT);
          else if (rows[r].pol == pol_bad_port)
            send_reply(8'd2, cur_xid, offer_ip[r], srv_ip[r], 16'd1067);
        end else begin
          check_request(r, cur_xid);
          req_n++;
          if (rows[r].nak_first && req_n == 1) begin
            send_reply(8'd6, cur_xid, 32'd0, srv_ip[r], DHCP_SRV_PORT);
            nak_xid   = cur_xid;
            after_nak = 1'b1;
          end else begin
            send_reply(8'd5, cur_xid, offer_ip[r], srv_ip[r], DHCP_SRV_PORT);
            assert (rows[r].exp_ok)
              else stop_run($sformatf("ERR %0t: row %0d got a lease, timeout expected", $time, r));
            check_lease(r, base_val);
            finished = 1'b1;
          end
        end
      end
      expect_equal(disc_n, rows[r].exp_disc, "discover count");
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== verilog/dhcp_client.sv ====
module dhcp_client (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           rx_v,
  input  logic [7:0]     rx_d,
  input  logic           rx_sof,
  input  logic           rx_eof,
  input  logic [15:0]    rx_src_port,
  input  net_pkg::mac_t  mac_addr,
  input  logic           ipv4_req,
  input  net_pkg::ipv4_t pref_ipv4,
  output logic           tx_v,
  output logic [7:0]     tx_d,
  output logic           tx_sof,
  output logic           tx_eof,
  output net_pkg::ipv4_t ipv4_addr,
  output logic           ipv4_val,
  output logic           dhcp_ok,
  output logic           dhcp_timeout
);

  import dhcp_pkg::*;
  import net_pkg::*;

  logic        reply_val;
  dhcp_msg_t   reply_msg;
  logic [31:0] reply_xid;
  ipv4_t       reply_yiaddr;
  ipv4_t       reply_srv_id;
  logic        tx_done;
  logic        send;
  dhcp_msg_t   send_msg;
  logic [31:0] xid;
  ipv4_t       req_ip;
  ipv4_t       srv_id;

  dhcp_core u_dhcp_core (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .ipv4_req     (ipv4_req),
    .pref_ipv4    (pref_ipv4),
    .reply_val    (reply_val),
    .reply_msg    (reply_msg),
    .reply_xid    (reply_xid),
    .reply_yiaddr (reply_yiaddr),
    .reply_srv_id (reply_srv_id),
    .tx_done      (tx_done),
    .send         (send),
    .send_msg     (send_msg),
    .xid          (xid),
    .req_ip       (req_ip),
    .srv_id       (srv_id),
    .ipv4_addr    (ipv4_addr),
    .ipv4_val     (ipv4_val),
    .dhcp_ok      (dhcp_ok),
    .dhcp_timeout (dhcp_timeout)
  );

  dhcp_rx u_dhcp_rx (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .rx_v         (rx_v),
    .rx_d         (rx_d),
    .rx_sof       (rx_sof),
    .rx_eof       (rx_eof),
    .rx_src_port  (rx_src_port),
    .reply_val    (reply_val),
    .reply_msg    (reply_msg),
    .reply_xid    (reply_xid),
    .reply_yiaddr (reply_yiaddr),
    .reply_srv_id (reply_srv_id)
  );

  dhcp_tx u_dhcp_tx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .send     (send),
    .send_msg (send_msg),
    .xid      (xid),
    .req_ip   (req_ip),
    .srv_id   (srv_id),
    .mac_addr (mac_addr),
    .tx_v     (tx_v),
    .tx_d     (tx_d),
    .tx_sof   (tx_sof),
    .tx_eof   (tx_eof),
    .tx_done  (tx_done)
  );

endmodule

// ==== verilog/dhcp_core.sv ====
module dhcp_core (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                ipv4_req,
  input  net_pkg::ipv4_t      pref_ipv4,
  input  logic                reply_val,
  input  dhcp_pkg::dhcp_msg_t reply_msg,
  input  logic [31:0]         reply_xid,
  input  net_pkg::ipv4_t      reply_yiaddr,
  input  net_pkg::ipv4_t      reply_srv_id,
  input  logic                tx_done,
  output logic                send,
  output dhcp_pkg::dhcp_msg_t send_msg,
  output logic [31:0]         xid,
  output net_pkg::ipv4_t      req_ip,
  output net_pkg::ipv4_t      srv_id,
  output net_pkg::ipv4_t      ipv4_addr,
  output logic                ipv4_val,
  output logic                dhcp_ok,
  output logic                dhcp_timeout
);

  import dhcp_pkg::*;

  core_state_t state;
  logic [1:0]  tries;   // sends of the current message
  logic [15:0] timer;
  logic        reply_hit;
  logic        waiting;
  logic        new_disc;
  logic        take_offer;
  logic        take_ack;
  logic        nak_hit;
  logic        expired;
  logic        xid_fb;

  assign reply_hit  = reply_val && (reply_xid == xid);
  assign waiting    = (state == wait_offer) || (state == wait_ack);
  assign take_offer = (state == wait_offer) && reply_hit && (reply_msg == msg_offer);
  assign take_ack   = (state == wait_ack) && reply_hit && (reply_msg == msg_ack);
  assign nak_hit    = (state == wait_ack) && reply_hit && (reply_msg == msg_nak);
  assign new_disc   = nak_hit ||
                      (ipv4_req && (state == idle || state == bound || state == failed));
  assign expired    = waiting && !take_offer && !take_ack && !nak_hit && (timer == 16'd1);
  assign xid_fb     = xid[31] ^ xid[21] ^ xid[1] ^ xid[0]; // x^32+x^22+x^2+x+1

  assign send_msg = (state == send_req) ? msg_request : msg_discover;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= idle;
      xid          <= XID_SEED;
      tries        <= 2'd0;
      timer        <= 16'd0;
      send         <= 1'b0;
      ipv4_val     <= 1'b0;
      dhcp_ok      <= 1'b0;
      dhcp_timeout <= 1'b0;
    end else begin
      send     <= new_disc || take_offer || (expired && tries != MAX_TRIES);
      ipv4_val <= take_ack;
      if (new_disc) begin
        state        <= send_disc;
        xid          <= {xid[30:0], xid_fb};
        tries        <= 2'd1;
        dhcp_ok      <= 1'b0;
        dhcp_timeout <= 1'b0;
      end else if (take_offer) begin
        state <= send_req;
        tries <= 2'd1;
      end else if (take_ack) begin
        state   <= bound;
        dhcp_ok <= 1'b1;
      end else if (expired) begin
        if (tries == MAX_TRIES) begin
          state        <= failed;
          dhcp_timeout <= 1'b1;
        end else begin
          state <= (state == wait_offer) ? send_disc : send_req; // same xid again
          tries <= tries + 2'd1;
        end
      end else if (tx_done && (state == send_disc || state == send_req)) begin
        state <= (state == send_disc) ? wait_offer : wait_ack;
        timer <= TIMEOUT_CYCLES;
      end else if (waiting) begin
        timer <= timer - 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (new_disc) req_ip <= pref_ipv4;
    if (take_offer) begin
      req_ip <= reply_yiaddr;
      srv_id <= reply_srv_id;
    end
    if (take_ack) ipv4_addr <= reply_yiaddr;
  end

  a_ok_xor_timeout: assert property (@(posedge clk) disable iff (fsm_rst)
    !(dhcp_ok && dhcp_timeout))
    else $error("dhcp_ok and dhcp_timeout both high");

endmodule

// ==== verilog/dhcp_pkg.sv ====
package dhcp_pkg;

  typedef enum logic [7:0] {
    msg_discover = 8'd1,
    msg_offer    = 8'd2,
    msg_request  = 8'd3,
    msg_ack      = 8'd5,
    msg_nak      = 8'd6
  } dhcp_msg_t;

  typedef enum logic [7:0] {
    opt_req_ip     = 8'd50,
    opt_lease_time = 8'd51,
    opt_msg_type   = 8'd53,
    opt_server_id  = 8'd54,
    opt_end        = 8'd255
  } dhcp_opt_code_t;

  typedef enum logic [1:0] {
    opt_kind,
    opt_len,
    opt_data
  } opt_field_t;

  typedef enum logic [2:0] {
    idle,
    send_disc,
    wait_offer,
    send_req,
    wait_ack,
    bound,
    failed
  } core_state_t;

  // byte offsets into the udp payload
  localparam logic [7:0] HDR_LEN    = 8'd240; // bootp header and cookie
  localparam logic [7:0] XID_OFS    = 8'd4;
  localparam logic [7:0] YIADDR_OFS = 8'd16;
  localparam logic [7:0] CHADDR_OFS = 8'd28;
  localparam logic [7:0] COOKIE_OFS = 8'd236;

  localparam logic [3:0][7:0] MAGIC_COOKIE = 32'h6382_5363;

  localparam logic [8:0] DISC_LEN = 9'd244; // header, msg_type, end
  localparam logic [8:0] REQ_LEN  = 9'd256; // adds req_ip and server_id

  localparam logic [15:0] TIMEOUT_CYCLES = 16'd1000;
  localparam logic [1:0]  MAX_TRIES      = 2'd3;
  localparam logic [31:0] XID_SEED       = 32'h5a3c_96e1; // any nonzero lfsr state

endpackage

// ==== verilog/dhcp_rx.sv ====
module dhcp_rx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic               rx_v,
  input  logic [7:0]         rx_d,
  input  logic               rx_sof,
  input  logic               rx_eof,
  input  logic [15:0]        rx_src_port,
  output logic               reply_val,
  output dhcp_pkg::dhcp_msg_t reply_msg,
  output logic [31:0]        reply_xid,
  output net_pkg::ipv4_t     reply_yiaddr,
  output net_pkg::ipv4_t     reply_srv_id
);

  import dhcp_pkg::*;
  import net_pkg::*;

  logic [15:0]     byte_cnt;
  logic [15:0]     idx;      // position of the byte on rx_d
  logic            sof_byte;
  logic            eof_byte;
  logic            parse_rst;
  logic            pkt_open;
  logic [7:0]      op_r;
  logic [31:0]     xid_r;
  ipv4_t           yiaddr_r;
  logic [31:0]     cookie_r;
  opt_field_t      opt_st;
  logic [7:0]      cur_kind;
  logic [7:0]      opt_left;
  logic            opt_done;
  logic            msg_seen;
  logic            opt_byte;
  logic            data_byte;
  logic [7:0]      msg_r;
  ipv4_t           srv_r;
  logic            reply_ok;

  assign sof_byte  = rx_v && rx_sof;
  assign eof_byte  = rx_v && rx_eof;
  assign parse_rst = fsm_rst || sof_byte;
  assign idx       = sof_byte ? 16'd0 : byte_cnt;
  assign opt_byte  = rx_v && (idx >= HDR_LEN) && !opt_done;
  assign data_byte = opt_byte && (opt_st == opt_data);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt <= 16'd0;
      pkt_open <= 1'b0;
    end else if (rx_v) begin
      byte_cnt <= (&idx) ? idx : idx + 16'd1; // saturate on oversized frames
      if (rx_eof) pkt_open <= 1'b0;
      else if (rx_sof) pkt_open <= 1'b1;
    end
  end

  // fixed header fields are picked off as they pass
  always_ff @(posedge clk) begin
    if (rx_v) begin
      if (idx == 16'd0) op_r <= rx_d;
      if (idx >= XID_OFS && idx < XID_OFS + 8'd4) xid_r <= {xid_r[23:0], rx_d};
      if (idx >= YIADDR_OFS && idx < YIADDR_OFS + 8'd4) yiaddr_r <= {yiaddr_r[2:0], rx_d};
      if (idx >= COOKIE_OFS && idx < HDR_LEN) cookie_r <= {cookie_r[23:0], rx_d};
    end
  end

  always_ff @(posedge clk) begin
    if (parse_rst) begin
      opt_st   <= opt_kind;
      cur_kind <= 8'd0;
      opt_left <= 8'd0;
      opt_done <= 1'b0;
      msg_seen <= 1'b0;
    end else if (opt_byte) begin
      case (opt_st)
        opt_kind: begin
          if (rx_d == opt_end) begin
            opt_done <= 1'b1;
          end else if (rx_d != 8'd0) begin // pad has no length byte
            cur_kind <= rx_d;
            opt_st   <= opt_len;
          end
        end
        opt_len: begin
          opt_left <= rx_d;
          opt_st   <= (rx_d == 8'd0) ? opt_kind : opt_data;
        end
        opt_data: begin
          if (cur_kind == opt_msg_type) msg_seen <= 1'b1;
          opt_left <= opt_left - 8'd1;
          if (opt_left == 8'd1) opt_st <= opt_kind; // unknown kinds just run out here
        end
        default: opt_st <= opt_kind;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (data_byte && cur_kind == opt_msg_type) msg_r <= rx_d;
    if (data_byte && cur_kind == opt_server_id) srv_r <= {srv_r[2:0], rx_d};
  end

  assign reply_ok = (rx_src_port == DHCP_SRV_PORT) && (op_r == 8'd2) &&
                    (cookie_r == MAGIC_COOKIE) && msg_seen && (idx >= HDR_LEN - 8'd1);

  always_ff @(posedge clk) begin
    if (fsm_rst) reply_val <= 1'b0;
    else reply_val <= eof_byte && reply_ok;
  end

  always_ff @(posedge clk) begin
    if (eof_byte && reply_ok) begin
      reply_msg    <= dhcp_msg_t'(msg_r);
      reply_xid    <= xid_r;
      reply_yiaddr <= yiaddr_r;
      reply_srv_id <= srv_r;
    end
  end

  a_sof_closed: assert property (@(posedge clk) disable iff (fsm_rst) sof_byte |-> !pkt_open)
    else $error("rx_sof while a packet is still open");

endmodule

// ==== verilog/dhcp_tx.sv ====
module dhcp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                send,
  input  dhcp_pkg::dhcp_msg_t send_msg,
  input  logic [31:0]         xid,
  input  net_pkg::ipv4_t      req_ip,
  input  net_pkg::ipv4_t      srv_id,
  input  net_pkg::mac_t       mac_addr,
  output logic                tx_v,
  output logic [7:0]          tx_d,
  output logic                tx_sof,
  output logic                tx_eof,
  output logic                tx_done
);

  import dhcp_pkg::*;
  import net_pkg::*;

  logic            busy;
  logic [8:0]      cnt;      // index of the byte now on tx_d
  logic [8:0]      last_idx;
  logic            is_req;
  dhcp_msg_t       msg_r;
  logic [3:0][7:0] xid_r;
  ipv4_t           req_ip_r;
  ipv4_t           srv_id_r;
  mac_t            mac_r;
  logic [8:0]      xid_i;
  logic [8:0]      mac_i;
  logic [8:0]      ck_i;
  logic [8:0]      opt_i;

  always_ff @(posedge clk) begin
    if (send) begin
      msg_r    <= send_msg;
      xid_r    <= xid;
      req_ip_r <= req_ip;
      srv_id_r <= srv_id;
      mac_r    <= mac_addr;
    end
  end

  assign is_req   = (msg_r == msg_request);
  assign last_idx = is_req ? REQ_LEN - 9'd1 : DISC_LEN - 9'd1;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy    <= 1'b0;
      cnt     <= 9'd0;
      tx_done <= 1'b0;
    end else begin
      tx_done <= tx_eof;
      if (send) begin
        busy <= 1'b1;
        cnt  <= 9'd0;
      end else if (busy) begin
        cnt <= cnt + 9'd1;
        if (cnt == last_idx) busy <= 1'b0;
      end
    end
  end

  assign tx_v   = busy;
  assign tx_sof = busy && (cnt == 9'd0);
  assign tx_eof = busy && (cnt == last_idx);

  assign xid_i = cnt - XID_OFS;
  assign mac_i = cnt - CHADDR_OFS;
  assign ck_i  = cnt - COOKIE_OFS;
  assign opt_i = cnt - HDR_LEN;

  always_comb begin
    tx_d = 8'h00; // unused header bytes stay zero
    if (cnt >= HDR_LEN) begin
      case (opt_i[3:0])
        4'd0:                      tx_d = opt_msg_type;
        4'd1:                      tx_d = 8'd1;
        4'd2:                      tx_d = msg_r;
        4'd3:                      tx_d = is_req ? opt_req_ip : opt_end;
        4'd4, 4'd10:               tx_d = 8'd4;
        4'd5, 4'd6, 4'd7, 4'd8:    tx_d = req_ip_r[2'(4'd8 - opt_i[3:0])];
        4'd9:                      tx_d = opt_server_id;
        4'd11, 4'd12, 4'd13, 4'd14: tx_d = srv_id_r[2'(4'd14 - opt_i[3:0])];
        default:                   tx_d = opt_end;
      endcase
    end else if (cnt >= COOKIE_OFS) begin
      tx_d = MAGIC_COOKIE[2'(9'd3 - ck_i)];
    end else if (cnt >= CHADDR_OFS && cnt < CHADDR_OFS + 8'd6) begin
      tx_d = mac_r[3'(9'd5 - mac_i)];
    end else if (cnt >= XID_OFS && cnt < XID_OFS + 8'd4) begin
      tx_d = xid_r[2'(9'd3 - xid_i)];
    end else if (cnt < 9'd2) begin
      tx_d = 8'd1; // op request, htype ethernet
    end else if (cnt == 9'd2) begin
      tx_d = 8'd6; // hlen
    end
  end

  a_send_idle: assert property (@(posedge clk) disable iff (fsm_rst) send |-> !busy)
    else $error("send while a packet is still going out");

endmodule

// ==== verilog/net_pkg.sv ====
package net_pkg;

  // multi-byte fields go out msb byte first, as on the wire
  typedef logic [3:0][7:0] ipv4_t;
  typedef logic [5:0][7:0] mac_t;

  localparam logic [15:0] DHCP_SRV_PORT = 16'd67; // server side
  localparam logic [15:0] DHCP_CLI_PORT = 16'd68; // client side

endpackage
